// File: Bender.yml
package:
  name: ecc_mem

sources:
  - ecc_pkg.sv
  - wb_mem_pkg.sv
  - ecc_secded_77.sv
  - ecc_mem_array.sv
  - ecc_mem_ctrl.sv
  - ecc_mem_top.sv
  - target: simulation
    files:
      - tb_ecc_mem.sv

// File: ecc_mem_array.sv
module ecc_mem_array (
    input  logic                              clk,
    input  logic [wb_mem_pkg::ADDR_WIDTH-1:0] rd_addr,
    output ecc_pkg::codeword_t                rd_data,
    input  logic                              wr_en,
    input  logic [wb_mem_pkg::ADDR_WIDTH-1:0] wr_addr,
    input  ecc_pkg::codeword_t                wr_data
);
    import ecc_pkg::*;
    import wb_mem_pkg::*;

    codeword_t mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr]; // one cycle from address to data.
    end

endmodule

// File: ecc_mem_ctrl.sv
module ecc_mem_ctrl (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              cyc,
    input  logic                              stb,
    input  logic                              we,
    input  logic [wb_mem_pkg::ADDR_WIDTH-1:0] adr,
    input  logic [ecc_pkg::DATA_WIDTH-1:0]    dat_w,
    input  wb_mem_pkg::inject_mode_t          inject_mode,
    input  logic [ecc_pkg::POS_WIDTH-1:0]     inject_pos_a,
    input  logic [ecc_pkg::POS_WIDTH-1:0]     inject_pos_b,
    input  logic                              bypass,
    output logic                              ack,
    output logic [ecc_pkg::DATA_WIDTH-1:0]    enc_data,
    input  logic [ecc_pkg::PARITY_WIDTH-1:0]  enc_parity,
    output logic                              dec_bypass,
    input  logic [ecc_pkg::DATA_WIDTH-1:0]    dec_data,
    input  logic                              dec_sbit,
    output logic [wb_mem_pkg::ADDR_WIDTH-1:0] rd_addr,
    input  ecc_pkg::codeword_t                rd_data,
    output logic                              wr_en,
    output logic [wb_mem_pkg::ADDR_WIDTH-1:0] wr_addr,
    output ecc_pkg::codeword_t                wr_data
);
    import ecc_pkg::*;
    import wb_mem_pkg::*;

    logic [1:0] state;
    logic       rd_q;
    logic       bypass_q;
    logic       req;
    logic       fix_cycle;
    logic       scrub;
    codeword_t  code_new;

    assign req       = (state == ST_IDLE) && cyc && stb;
    assign ack       = (state == ST_ACK);
    assign fix_cycle = ack && rd_q; // the decoded word is on dec_data now.

    assign dec_bypass = bypass_q;
    assign rd_addr    = adr; // master holds adr until it sees ack.
    assign wr_addr    = adr;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            rd_q     <= 1'b0;
            bypass_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cyc && stb) begin
                        rd_q     <= !we;
                        bypass_q <= !we && bypass;
                        state    <= we ? ST_ACK : ST_RD_WAIT;
                    end
                end
                ST_RD_WAIT: state <= ST_ACK;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    assign enc_data = fix_cycle ? dec_data : dat_w;

    always_comb begin
        code_new.fld.check = enc_parity;
        code_new.fld.data  = enc_data;
        wr_data            = code_new;
        if (!fix_cycle) begin
            case (inject_mode)
                INJ_SINGLE: begin
                    wr_data.flat[inject_pos_a] = !wr_data.flat[inject_pos_a];
                end
                INJ_DOUBLE: begin
                    wr_data.flat[inject_pos_a] = !wr_data.flat[inject_pos_a];
                    wr_data.flat[inject_pos_b] = !wr_data.flat[inject_pos_b];
                end
                default: ;
            endcase
        end
    end

    // Double errors are never rewritten, since the decoder cannot repair them.
    assign scrub = fix_cycle && dec_sbit && (code_new.flat != rd_data.flat);
    assign wr_en = (req && we) || scrub; // writes land at the edge that raises ack.

endmodule

// File: ecc_mem_top.sv
module ecc_mem_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              cyc,
    input  logic                              stb,
    input  logic                              we,
    input  logic [wb_mem_pkg::ADDR_WIDTH-1:0] adr,
    input  logic [ecc_pkg::DATA_WIDTH-1:0]    dat_w,
    output logic [ecc_pkg::DATA_WIDTH-1:0]    dat_r,
    output logic                              ack,
    input  wb_mem_pkg::inject_mode_t          inject_mode,
    input  logic [ecc_pkg::POS_WIDTH-1:0]     inject_pos_a,
    input  logic [ecc_pkg::POS_WIDTH-1:0]     inject_pos_b,
    input  logic                              bypass,
    output logic                              sbit_err,
    output logic                              dbit_err
);
    import ecc_pkg::*;
    import wb_mem_pkg::*;

    logic [DATA_WIDTH-1:0]   enc_data;
    logic [PARITY_WIDTH-1:0] enc_parity;
    logic                    dec_bypass;
    logic [ADDR_WIDTH-1:0]   rd_addr;
    logic [ADDR_WIDTH-1:0]   wr_addr;
    logic                    wr_en;
    codeword_t               rd_data;
    codeword_t               wr_data;

    ecc_mem_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .dat_w        (dat_w),
        .inject_mode  (inject_mode),
        .inject_pos_a (inject_pos_a),
        .inject_pos_b (inject_pos_b),
        .bypass       (bypass),
        .ack          (ack),
        .enc_data     (enc_data),
        .enc_parity   (enc_parity),
        .dec_bypass   (dec_bypass),
        .dec_data     (dat_r),
        .dec_sbit     (sbit_err),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data)
    );

    // only the check bits of the write-path instance are used.
    ecc_secded_77 u_enc (
        .data_in    (enc_data),
        .parity_in  ('0),
        .bypass     (1'b1),
        .data_out   (),
        .parity_out (enc_parity),
        .sbit_err   (),
        .dbit_err   ()
    );

    ecc_secded_77 u_dec (
        .data_in    (rd_data.fld.data),
        .parity_in  (rd_data.fld.check),
        .bypass     (dec_bypass),
        .data_out   (dat_r),
        .parity_out (),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    ecc_mem_array u_array (
        .clk     (clk),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

endmodule

// File: ecc_pkg.sv
package ecc_pkg;

    localparam int DATA_WIDTH   = 77;
    localparam int PARITY_WIDTH = 8;
    localparam int CODE_WIDTH   = DATA_WIDTH + PARITY_WIDTH;
    localparam int POS_WIDTH    = $clog2(CODE_WIDTH); // enough to index every codeword bit.

    // The decoder reads the check and data fields, while error injection
    // flips single bits through the flat view.
    typedef union packed {
        struct packed {
            logic [PARITY_WIDTH-1:0] check; // upper bits of the stored word.
            logic [DATA_WIDTH-1:0]   data;
        } fld;
        logic [CODE_WIDTH-1:0] flat;
    } codeword_t;

endpackage

// File: ecc_secded_77.sv
module ecc_secded_77 (
    input  logic [ecc_pkg::DATA_WIDTH-1:0]   data_in,
    input  logic [ecc_pkg::PARITY_WIDTH-1:0] parity_in,
    input  logic                             bypass,
    output logic [ecc_pkg::DATA_WIDTH-1:0]   data_out,
    output logic [ecc_pkg::PARITY_WIDTH-1:0] parity_out,
    output logic                             sbit_err,
    output logic                             dbit_err
);
    import ecc_pkg::*;

    logic [PARITY_WIDTH-1:0] syndrome;
    logic [DATA_WIDTH-1:0]   mask;
    logic                    data_hit;
    logic                    check_hit;
    logic                    single;

    // Hamming positions 3..84 without the powers of two, and p[7] makes
    // every column odd weight so that two flips never alias a single one.
    function automatic logic [PARITY_WIDTH-1:0] ecc_encode(input logic [DATA_WIDTH-1:0] d);
        logic [PARITY_WIDTH-1:0] p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[11] ^ d[13] ^ d[15]
             ^ d[17] ^ d[19] ^ d[21] ^ d[23] ^ d[25] ^ d[26] ^ d[28] ^ d[30] ^ d[32]
             ^ d[34] ^ d[36] ^ d[38] ^ d[40] ^ d[42] ^ d[44] ^ d[46] ^ d[48] ^ d[50]
             ^ d[52] ^ d[54] ^ d[56] ^ d[57] ^ d[59] ^ d[61] ^ d[63] ^ d[65] ^ d[67]
             ^ d[69] ^ d[71] ^ d[73] ^ d[75];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[10] ^ d[12] ^ d[13] ^ d[16]
             ^ d[17] ^ d[20] ^ d[21] ^ d[24] ^ d[25] ^ d[27] ^ d[28] ^ d[31] ^ d[32]
             ^ d[35] ^ d[36] ^ d[39] ^ d[40] ^ d[43] ^ d[44] ^ d[47] ^ d[48] ^ d[51]
             ^ d[52] ^ d[55] ^ d[56] ^ d[58] ^ d[59] ^ d[62] ^ d[63] ^ d[66] ^ d[67]
             ^ d[70] ^ d[71] ^ d[74] ^ d[75];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[14] ^ d[15] ^ d[16]
             ^ d[17] ^ d[22] ^ d[23] ^ d[24] ^ d[25] ^ d[29] ^ d[30] ^ d[31] ^ d[32]
             ^ d[37] ^ d[38] ^ d[39] ^ d[40] ^ d[45] ^ d[46] ^ d[47] ^ d[48] ^ d[53]
             ^ d[54] ^ d[55] ^ d[56] ^ d[60] ^ d[61] ^ d[62] ^ d[63] ^ d[68] ^ d[69]
             ^ d[70] ^ d[71] ^ d[76];
        p[3] = (^d[10:4]) ^ (^d[25:18]) ^ (^d[40:33]) ^ (^d[56:49]) ^ (^d[71:64]);
        p[4] = (^d[25:11]) ^ (^d[56:41]) ^ (^d[76:72]);
        p[5] = ^d[56:26];
        p[6] = ^d[76:57];
        p[7] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[12] ^ d[14]
             ^ d[17] ^ d[18] ^ d[21] ^ d[23] ^ d[24] ^ d[26] ^ d[27] ^ d[29] ^ d[32]
             ^ d[33] ^ d[36] ^ d[38] ^ d[39] ^ d[41] ^ d[44] ^ d[46] ^ d[47] ^ d[50]
             ^ d[51] ^ d[53] ^ d[56] ^ d[57] ^ d[58] ^ d[60] ^ d[63] ^ d[64] ^ d[67]
             ^ d[69] ^ d[70] ^ d[72] ^ d[75];
        return p;
    endfunction

    assign parity_out = ecc_encode(data_in);
    assign syndrome   = parity_in ^ parity_out;

    always_comb begin
        for (int i = 0; i < DATA_WIDTH; i++) begin
            mask[i] = (syndrome == ecc_encode(DATA_WIDTH'(1) << i)); // column i of the code.
        end
    end

    assign data_hit  = |mask;
    assign check_hit = (syndrome != '0) && ((syndrome & (syndrome - 1'b1)) == '0);
    assign single    = data_hit || check_hit; // a flipped check bit leaves the data as is.

    assign data_out = bypass ? data_in : data_in ^ mask;
    assign sbit_err = !bypass && single;
    assign dbit_err = !bypass && (syndrome != '0) && !single;

endmodule

// File: sim.f
ecc_pkg.sv
wb_mem_pkg.sv
ecc_secded_77.sv
ecc_mem_array.sv
ecc_mem_ctrl.sv
ecc_mem_top.sv
tb_ecc_mem.sv

// File: tb_ecc_mem.sv
module tb_ecc_mem;
    timeunit 1ns;
    timeprecision 1ps;

    import ecc_pkg::*;
    import wb_mem_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int N_CLEAN      = 20;
    localparam int N_SINGLE     = 12;
    localparam int N_DOUBLE     = 10;
    localparam int N_BYPASS     = 8;
    localparam int NUM_ACCESSES = 2 * N_CLEAN + 3 * N_SINGLE + 3 * N_DOUBLE + 3 * N_BYPASS;

    logic                    clk;
    logic                    reset;
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [ADDR_WIDTH-1:0]   adr;
    logic [DATA_WIDTH-1:0]   dat_w;
    logic [DATA_WIDTH-1:0]   dat_r;
    logic                    ack;
    inject_mode_t            inject_mode;
    logic [POS_WIDTH-1:0]    inject_pos_a;
    logic [POS_WIDTH-1:0]    inject_pos_b;
    logic                    bypass;
    logic                    sbit_err;
    logic                    dbit_err;

    integer seed;
    logic   read_active;
    logic [DATA_WIDTH-1:0] exp_data;
    logic   exp_sbit;
    logic   exp_dbit;
    int     reads_issued;
    int     reads_checked;

    // expected state of each word is the written data plus the flips on top of it.
    logic [DATA_WIDTH-1:0] model_data  [MEM_DEPTH];
    int                    model_nflip [MEM_DEPTH];
    logic [POS_WIDTH-1:0]  model_pos_a [MEM_DEPTH];
    logic [POS_WIDTH-1:0]  model_pos_b [MEM_DEPTH];

    ecc_mem_top dut (
        .clk          (clk),
        .reset        (reset),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .dat_w        (dat_w),
        .dat_r        (dat_r),
        .ack          (ack),
        .inject_mode  (inject_mode),
        .inject_pos_a (inject_pos_a),
        .inject_pos_b (inject_pos_b),
        .bypass       (bypass),
        .sbit_err     (sbit_err),
        .dbit_err     (dbit_err)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] expected);
        if (got !== expected) begin
            $display("ERROR: %s got 0x%0h expected 0x%0h", name, got, expected);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    function automatic logic [DATA_WIDTH-1:0] rand_word();
        logic [95:0] w;
        w[31:0]  = $random(seed);
        w[63:32] = $random(seed);
        w[95:64] = $random(seed);
        return w[DATA_WIDTH-1:0];
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] rand_addr();
        int r;
        r = $random(seed);
        return r[ADDR_WIDTH-1:0];
    endfunction

    function automatic logic [POS_WIDTH-1:0] rand_pos();
        int unsigned r;
        r = $random(seed);
        return POS_WIDTH'(r % CODE_WIDTH);
    endfunction

    // Returns {dat_r, sbit_err, dbit_err} for a read of address a.
    function automatic logic [DATA_WIDTH+1:0] expect_read(input logic [ADDR_WIDTH-1:0] a,
                                                         input logic byp);
        logic [DATA_WIDTH-1:0] raw;
        logic [POS_WIDTH-1:0]  p;
        raw = model_data[a];
        for (int i = 0; i < model_nflip[a]; i++) begin
            p = (i == 0) ? model_pos_a[a] : model_pos_b[a];
            if (p < DATA_WIDTH) begin
                raw[p] = ~raw[p]; // flips in the check field leave the data alone.
            end
        end
        if (byp) begin
            return {raw, 2'b00};
        end
        case (model_nflip[a])
            0:       return {model_data[a], 2'b00};
            1:       return {model_data[a], 2'b10};
            default: return {raw, 2'b01};
        endcase
    endfunction

    task automatic wb_write(input logic [ADDR_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] d,
                            input inject_mode_t mode, input logic [POS_WIDTH-1:0] pa,
                            input logic [POS_WIDTH-1:0] pb);
        int lat;
        @(negedge clk);
        cyc          = 1'b1;
        stb          = 1'b1;
        we           = 1'b1;
        adr          = a;
        dat_w        = d;
        inject_mode  = mode;
        inject_pos_a = pa;
        inject_pos_b = pb;
        lat          = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!ack);
        check_value("write ack latency", lat, 1);
        cyc         = 1'b0;
        stb         = 1'b0;
        we          = 1'b0;
        inject_mode = INJ_NONE;
        @(negedge clk);
        check_value("ack", ack, 0); // ack lasts one cycle only.
        model_data[a]  = d;
        model_nflip[a] = (mode == INJ_SINGLE) ? 1 : (mode == INJ_DOUBLE) ? 2 : 0;
        model_pos_a[a] = pa;
        model_pos_b[a] = pb;
    endtask

    task automatic wb_read(input logic [ADDR_WIDTH-1:0] a, input logic byp);
        int lat;
        @(negedge clk);
        {exp_data, exp_sbit, exp_dbit} = expect_read(a, byp);
        read_active = 1'b1;
        cyc         = 1'b1;
        stb         = 1'b1;
        we          = 1'b0;
        adr         = a;
        bypass      = byp;
        lat         = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!ack);
        check_value("read ack latency", lat, 2);
        cyc         = 1'b0;
        stb         = 1'b0;
        bypass      = 1'b0;
        reads_issued++;
        @(negedge clk);
        check_value("ack", ack, 0);
        read_active = 1'b0;
        if (!byp && model_nflip[a] == 1) begin
            model_nflip[a] = 0; // the corrected word was written back.
        end
    endtask

    always @(negedge clk) begin
        if (ack && read_active) begin
            check_value("dat_r", dat_r, exp_data);
            check_value("sbit_err", sbit_err, exp_sbit);
            check_value("dbit_err", dbit_err, exp_dbit);
            reads_checked++;
        end
    end

    initial begin
        repeat (NUM_ACCESSES * 10 + RESET_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within the expected number of cycles");
        $display("FAIL: see errors above");
        $fatal(1);
    end

    initial begin
        logic [ADDR_WIDTH-1:0] addrs [N_CLEAN];
        logic [ADDR_WIDTH-1:0] a;
        logic [POS_WIDTH-1:0]  pa;
        logic [POS_WIDTH-1:0]  pb;
        inject_mode_t          mode;
        int                    r;
        seed          = 54603;
        reset         = 1'b1;
        cyc           = 1'b0;
        stb           = 1'b0;
        we            = 1'b0;
        adr           = '0;
        dat_w         = '0;
        inject_mode   = INJ_NONE;
        inject_pos_a  = '0;
        inject_pos_b  = '0;
        bypass        = 1'b0;
        read_active   = 1'b0;
        exp_data      = '0;
        exp_sbit      = 1'b0;
        exp_dbit      = 1'b0;
        reads_issued  = 0;
        reads_checked = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < N_CLEAN; i++) begin
            addrs[i] = rand_addr();
            wb_write(addrs[i], rand_word(), INJ_NONE, '0, '0);
        end
        for (int i = 0; i < N_CLEAN; i++) begin
            wb_read(addrs[i], 1'b0);
        end

        for (int i = 0; i < N_SINGLE; i++) begin
            a  = rand_addr();
            pa = rand_pos();
            wb_write(a, rand_word(), INJ_SINGLE, pa, '0);
            wb_read(a, 1'b0);
            wb_read(a, 1'b0); // should come back clean after the scrub.
        end

        for (int i = 0; i < N_DOUBLE; i++) begin
            a  = rand_addr();
            pa = rand_pos();
            do begin
                pb = rand_pos();
            end while (pb == pa);
            wb_write(a, rand_word(), INJ_DOUBLE, pa, pb);
            wb_read(a, 1'b0);
            wb_read(a, 1'b0);
        end

        for (int i = 0; i < N_BYPASS; i++) begin
            a  = rand_addr();
            pa = rand_pos();
            do begin
                pb = rand_pos();
            end while (pb == pa);
            r    = $random(seed);
            mode = r[0] ? INJ_DOUBLE : INJ_SINGLE;
            wb_write(a, rand_word(), mode, pa, pb);
            wb_read(a, 1'b1);
            wb_read(a, 1'b0); // bypass must not have scrubbed the word.
        end

        if (reads_checked == reads_issued) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("compare process saw %0d of %0d reads", reads_checked, reads_issued);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

endmodule

// File: wb_mem_pkg.sv
package wb_mem_pkg;

    localparam int MEM_DEPTH  = 64;
    localparam int ADDR_WIDTH = $clog2(MEM_DEPTH);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_RD_WAIT = 2'd1; // array output settles here.
    localparam logic [1:0] ST_ACK     = 2'd2;

    typedef enum logic [1:0] {
        INJ_NONE   = 2'd0,
        INJ_SINGLE = 2'd1,
        INJ_DOUBLE = 2'd2
    } inject_mode_t;

endpackage
